//--- src.f
hw/mem_bus_pkg.sv
hw/mem_port_cfg_pkg.sv
hw/mem_req_if.sv
hw/fetch_port.sv
hw/dmem_port.sv
hw/mem_port_arbiter.sv
hw/mem_port_top.sv
verif/mem_bus_model.sv
verif/tb_mem_port_top.sv

//--- Bender.yml
package:
  name: mem_port

sources:
  - hw/mem_bus_pkg.sv
  - hw/mem_port_cfg_pkg.sv
  - hw/mem_req_if.sv
  - hw/fetch_port.sv
  - hw/dmem_port.sv
  - hw/mem_port_arbiter.sv
  - hw/mem_port_top.sv
  - target: test
    files:
      - verif/mem_bus_model.sv
      - verif/tb_mem_port_top.sv

//--- verif/tb_mem_port_top.sv
`timescale 1ns/1ps

module tb_mem_port_top;

	localparam mem_bus_pkg::mem_data_t MEM_PATTERN = 64'h5a5a_c3c3_0ff0_9669;
	localparam mem_bus_pkg::mem_addr_t FETCH_BASE  = 64'h1000;
	localparam mem_bus_pkg::mem_addr_t DMEM_BASE   = 64'h8000;
	localparam int SEED      = 7;
	localparam int MAX_STALL = 3;
	localparam int MAX_LAT   = 6;
	localparam int N_REQ     = 31;
	// per request a stall run, a full return latency and one arbitration turn
	localparam int CYCLE_LIMIT =
		2 * N_REQ * (MAX_STALL + MAX_LAT + mem_port_cfg_pkg::ARB_VEC_W) + 64;

	logic                   clk;
	logic                   rst;
	logic                   fetch_req_i;
	mem_bus_pkg::mem_addr_t fetch_addr_i;
	logic                   fetch_busy_o;
	logic                   fetch_valid_o;
	mem_bus_pkg::mem_data_t fetch_data_o;
	logic                   dmem_req_i;
	logic                   dmem_we_i;
	mem_bus_pkg::mem_addr_t dmem_addr_i;
	mem_bus_pkg::mem_data_t dmem_wdata_i;
	logic                   dmem_busy_o;
	logic                   dmem_ld_valid_o;
	mem_bus_pkg::mem_data_t dmem_ld_data_o;
	logic                   dmem_st_done_o;
	mem_bus_pkg::mem_tag_t  mem2proc_response_i;
	mem_bus_pkg::mem_data_t mem2proc_data_i;
	mem_bus_pkg::mem_tag_t  mem2proc_tag_i;
	mem_bus_pkg::mem_cmd_e  proc2mem_command_o;
	mem_bus_pkg::mem_addr_t proc2mem_addr_o;
	mem_bus_pkg::mem_data_t proc2mem_data_o;

	mem_bus_pkg::mem_data_t shadow [mem_bus_pkg::mem_addr_t];
	mem_bus_pkg::mem_data_t fetch_exp;
	mem_bus_pkg::mem_data_t dmem_exp;
	string                  test_name;
	logic                   rst_q = 1'b0;
	logic                   both_busy;
	int                     errors;
	int                     err_mark;
	int                     tests;
	int                     requests;
	int                     pulses;
	int                     cycles;

	mem_port_top i_mem_port_top (.*);

	mem_bus_model #(
		.PATTERN   (MEM_PATTERN),
		.MAX_STALL (MAX_STALL),
		.MAX_LAT   (MAX_LAT)
	) i_mem_bus_model (
		.clk        (clk),
		.rst        (rst),
		.cmd_i      (proc2mem_command_o),
		.addr_i     (proc2mem_addr_o),
		.data_i     (proc2mem_data_o),
		.response_o (mem2proc_response_i),
		.data_o     (mem2proc_data_i),
		.tag_o      (mem2proc_tag_i)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) rst_q <= rst;

	always @(posedge clk)
		if (!rst)
			pulses <= pulses + fetch_valid_o + dmem_ld_valid_o + dmem_st_done_o;

	assign both_busy = fetch_busy_o && dmem_busy_o;

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	a_fetch_word: assert property (@(posedge clk) disable iff (rst)
		fetch_valid_o |-> (fetch_data_o == fetch_exp))
		else begin
			$display("FAILED %s expected %h actual %h", test_name, fetch_exp, fetch_data_o);
			errors++;
		end

	a_load_word: assert property (@(posedge clk) disable iff (rst)
		dmem_ld_valid_o |-> (dmem_ld_data_o == dmem_exp))
		else begin
			$display("FAILED %s expected %h actual %h", test_name, dmem_exp, dmem_ld_data_o);
			errors++;
		end

	a_fetch_pulse: assert property (@(posedge clk) disable iff (rst)
		fetch_valid_o |=> !fetch_valid_o)
		else begin
			$display("%s: fetch valid stayed high for more than one cycle", test_name);
			errors++;
		end

	a_dmem_pulse: assert property (@(posedge clk) disable iff (rst)
		(dmem_ld_valid_o || dmem_st_done_o) |=> !(dmem_ld_valid_o || dmem_st_done_o))
		else begin
			$display("%s: data port pulse lasted more than one cycle", test_name);
			errors++;
		end

	// with a single active port the bus itself must hold under stall
	a_bus_hold: assert property (@(posedge clk) disable iff (rst)
		(proc2mem_command_o != mem_bus_pkg::BUS_NONE && mem2proc_response_i == '0
			&& !both_busy) ##1 !both_busy
		|-> ($stable(proc2mem_command_o) && $stable(proc2mem_addr_o)
			&& $stable(proc2mem_data_o)))
		else begin
			$display("%s: bus command changed while stalled", test_name);
			errors++;
		end

	a_reset_idle: assert property (@(posedge clk)
		rst_q |-> (!fetch_busy_o && !dmem_busy_o && !fetch_valid_o && !dmem_ld_valid_o
			&& !dmem_st_done_o && proc2mem_command_o == mem_bus_pkg::BUS_NONE))
		else begin
			$display("%s: outputs not idle during or right after reset", test_name);
			errors++;
		end

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	function automatic mem_bus_pkg::mem_data_t expected_word(input mem_bus_pkg::mem_addr_t a);
		return shadow.exists(a) ? shadow[a] : (a ^ MEM_PATTERN);
	endfunction

	function automatic mem_bus_pkg::mem_addr_t pick_addr(input mem_bus_pkg::mem_addr_t base);
		return base + {$urandom_range(255, 0), 3'b000};
	endfunction

	task automatic run_fetch(input mem_bus_pkg::mem_addr_t addr);
		fetch_req_i  = 1'b1;
		fetch_addr_i = addr;
		fetch_exp    = expected_word(addr);
		requests++;
		@(negedge clk);
		fetch_req_i = 1'b0;
		while (!fetch_valid_o)
			@(negedge clk);
		// keep the expected word until the pulse is checked
		@(negedge clk);
	endtask

	task automatic run_dmem(input logic we, input mem_bus_pkg::mem_addr_t addr,
		input mem_bus_pkg::mem_data_t wdata);
		dmem_req_i   = 1'b1;
		dmem_we_i    = we;
		dmem_addr_i  = addr;
		dmem_wdata_i = wdata;
		if (we)
			shadow[addr] = wdata;
		else
			dmem_exp = expected_word(addr);
		requests++;
		@(negedge clk);
		dmem_req_i = 1'b0;
		while (!(dmem_ld_valid_o || dmem_st_done_o))
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark  = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("%-16s %s", test_name, (errors == err_mark) ? "ok" : "errors");
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		mem_bus_pkg::mem_addr_t a;
		mem_bus_pkg::mem_addr_t fa;
		mem_bus_pkg::mem_data_t wd;
		logic                   we;
		void'($urandom(SEED));
		rst          = 1'b1;
		fetch_req_i  = 1'b0;
		fetch_addr_i = '0;
		dmem_req_i   = 1'b0;
		dmem_we_i    = 1'b0;
		dmem_addr_i  = '0;
		dmem_wdata_i = '0;
		start_test("reset_state");
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		end_test();

		start_test("fetch_only");
		for (int i = 0; i < 4; i++)
			run_fetch(pick_addr(FETCH_BASE));
		end_test();

		start_test("load_only");
		for (int i = 0; i < 4; i++)
			run_dmem(1'b0, pick_addr(DMEM_BASE), '0);
		end_test();

		start_test("store_then_load");
		a = pick_addr(DMEM_BASE);
		run_dmem(1'b1, a, {$urandom, $urandom});
		run_dmem(1'b0, a, '0);
		run_fetch(a);
		end_test();

		start_test("contention");
		for (int i = 0; i < 4; i++) begin
			fa = pick_addr(FETCH_BASE);
			a  = pick_addr(DMEM_BASE);
			fork
				run_fetch(fa);
				run_dmem(1'b0, a, '0);
			join
		end
		end_test();

		start_test("stall_hold");
		for (int i = 0; i < 6; i++) begin
			fa = pick_addr(FETCH_BASE);
			a  = pick_addr(DMEM_BASE);
			wd = {$urandom, $urandom};
			we = $urandom_range(1, 0);
			fork
				run_fetch(fa);
				run_dmem(we, a, wd);
			join
		end
		assert (pulses == requests)
		else begin
			$display("%s: %0d pulses seen for %0d requests", test_name, pulses, requests);
			errors++;
		end
		end_test();

		$display("tests %0d, requests %0d, failed checks %0d", tests, requests, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles with a request still open", cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule : tb_mem_port_top

//--- verif/mem_bus_model.sv
`timescale 1ns/1ps

// tagged memory with random stalls and out-of-order load returns
module mem_bus_model #(
	parameter mem_bus_pkg::mem_data_t PATTERN   = '0,
	parameter int                     MAX_STALL = 3,
	parameter int                     MAX_LAT   = 6
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_bus_pkg::mem_cmd_e  cmd_i,
	input  mem_bus_pkg::mem_addr_t addr_i,
	input  mem_bus_pkg::mem_data_t data_i,
	output mem_bus_pkg::mem_tag_t  response_o,
	output mem_bus_pkg::mem_data_t data_o,
	output mem_bus_pkg::mem_tag_t  tag_o
);

	mem_bus_pkg::mem_data_t mem [mem_bus_pkg::mem_addr_t];
	mem_bus_pkg::mem_data_t ret_data [16];
	int                     ret_wait [16];
	logic [15:0]            pend     = '0;
	mem_bus_pkg::mem_tag_t  next_tag = 4'h1;
	logic                   stall    = 1'b1;
	int                     stall_run;
	mem_bus_pkg::mem_tag_t  tag_r    = '0;
	mem_bus_pkg::mem_data_t data_r   = '0;

	// unwritten words read as address xor pattern
	function automatic mem_bus_pkg::mem_data_t read_word(input mem_bus_pkg::mem_addr_t a);
		return mem.exists(a) ? mem[a] : (a ^ PATTERN);
	endfunction

	// accept in the same cycle unless stalled or the tag is still in flight
	assign response_o = (cmd_i != mem_bus_pkg::BUS_NONE && !stall && !pend[next_tag])
	                    ? next_tag : '0;
	assign tag_o  = tag_r;
	assign data_o = data_r;

	always @(posedge clk) begin : model
		logic stall_now;
		int   pick;
		pick = 0;
		if (rst) begin
			pend      <= '0;
			next_tag  <= 4'h1;
			stall     <= 1'b0;
			stall_run <= 0;
			tag_r     <= '0;
		end else begin
			// stall runs never exceed MAX_STALL cycles
			stall_now = (stall_run < MAX_STALL) && ($urandom % 3 == 0);
			stall     <= stall_now;
			stall_run <= stall_now ? stall_run + 1 : 0;
			if (response_o != '0) begin
				next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
				if (cmd_i == mem_bus_pkg::BUS_STORE) begin
					mem[addr_i] = data_i;
				end else begin
					ret_data[response_o] = read_word(addr_i);
					ret_wait[response_o] = 1 + ($urandom % MAX_LAT);
					pend[response_o]    <= 1'b1;
				end
			end
			// -------------------------------------------------
			// one return per cycle, lowest ready tag first
			// -------------------------------------------------
			tag_r <= '0;
			for (int t = 1; t < 16; t++) begin
				if (pend[t] && ret_wait[t] > 0)
					ret_wait[t]--;
				if (pend[t] && ret_wait[t] == 0 && pick == 0)
					pick = t;
			end
			if (pick != 0) begin
				tag_r      <= pick[3:0];
				data_r     <= ret_data[pick];
				pend[pick] <= 1'b0;
			end
		end
	end

endmodule : mem_bus_model

//--- hw/mem_port_top.sv
`timescale 1ns/1ps

module mem_port_top (
	input  logic                   clk,
	input  logic                   rst,

	// instruction fetch side
	input  logic                   fetch_req_i,
	input  mem_bus_pkg::mem_addr_t fetch_addr_i,
	output logic                   fetch_busy_o,
	output logic                   fetch_valid_o,
	output mem_bus_pkg::mem_data_t fetch_data_o,

	// data side
	input  logic                   dmem_req_i,
	input  logic                   dmem_we_i,
	input  mem_bus_pkg::mem_addr_t dmem_addr_i,
	input  mem_bus_pkg::mem_data_t dmem_wdata_i,
	output logic                   dmem_busy_o,
	output logic                   dmem_ld_valid_o,
	output mem_bus_pkg::mem_data_t dmem_ld_data_o,
	output logic                   dmem_st_done_o,

	// shared tagged memory bus
	input  mem_bus_pkg::mem_tag_t  mem2proc_response_i,
	input  mem_bus_pkg::mem_data_t mem2proc_data_i,
	input  mem_bus_pkg::mem_tag_t  mem2proc_tag_i,
	output mem_bus_pkg::mem_cmd_e  proc2mem_command_o,
	output mem_bus_pkg::mem_addr_t proc2mem_addr_o,
	output mem_bus_pkg::mem_data_t proc2mem_data_o
);

	mem_req_if fetch_bus ();
	mem_req_if dmem_bus ();

	// --------------------------------------------------
	// requesters, both see the broadcast return data
	// --------------------------------------------------
	fetch_port i_fetch_port (
		.clk             (clk),
		.rst             (rst),
		.fetch_req_i     (fetch_req_i),
		.fetch_addr_i    (fetch_addr_i),
		.mem2proc_tag_i  (mem2proc_tag_i),
		.mem2proc_data_i (mem2proc_data_i),
		.fetch_busy_o    (fetch_busy_o),
		.fetch_valid_o   (fetch_valid_o),
		.fetch_data_o    (fetch_data_o),
		.bus             (fetch_bus.requester)
	);

	dmem_port i_dmem_port (
		.clk             (clk),
		.rst             (rst),
		.dmem_req_i      (dmem_req_i),
		.dmem_we_i       (dmem_we_i),
		.dmem_addr_i     (dmem_addr_i),
		.dmem_wdata_i    (dmem_wdata_i),
		.mem2proc_tag_i  (mem2proc_tag_i),
		.mem2proc_data_i (mem2proc_data_i),
		.dmem_busy_o     (dmem_busy_o),
		.dmem_ld_valid_o (dmem_ld_valid_o),
		.dmem_ld_data_o  (dmem_ld_data_o),
		.dmem_st_done_o  (dmem_st_done_o),
		.bus             (dmem_bus.requester)
	);

	// single command onto the bus
	mem_port_arbiter i_mem_port_arbiter (
		.clk                 (clk),
		.rst                 (rst),
		.fetch               (fetch_bus.arbiter),
		.dmem                (dmem_bus.arbiter),
		.mem2proc_response_i (mem2proc_response_i),
		.proc2mem_command_o  (proc2mem_command_o),
		.proc2mem_addr_o     (proc2mem_addr_o),
		.proc2mem_data_o     (proc2mem_data_o)
	);

endmodule : mem_port_top

//--- hw/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	mem_req_if.arbiter             fetch,
	mem_req_if.arbiter             dmem,
	input  mem_bus_pkg::mem_tag_t  mem2proc_response_i,
	output mem_bus_pkg::mem_cmd_e  proc2mem_command_o,
	output mem_bus_pkg::mem_addr_t proc2mem_addr_o,
	output mem_bus_pkg::mem_data_t proc2mem_data_o
);

	logic [mem_port_cfg_pkg::ARB_VEC_W-1:0] arb_vec_r;
	logic                                   fetch_has_cmd;
	logic                                   dmem_has_cmd;
	logic                                   fetch_wins;

	// --------------------------------------------------
	// rotating priority vector
	// --------------------------------------------------
	// bit 0 set means fetch is favored this cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			arb_vec_r <= {{(mem_port_cfg_pkg::ARB_VEC_W-1){1'b0}}, 1'b1};
		end else begin
			arb_vec_r <= {arb_vec_r[0], arb_vec_r[mem_port_cfg_pkg::ARB_VEC_W-1:1]};
		end
	end

	assign fetch_has_cmd = (fetch.cmd != mem_bus_pkg::BUS_NONE);
	assign dmem_has_cmd  = (dmem.cmd != mem_bus_pkg::BUS_NONE);

	// favored side wins if it has work, otherwise the other side
	assign fetch_wins = arb_vec_r[0] ? fetch_has_cmd : !dmem_has_cmd;

	// --------------------------------------------------
	// bus mux and response steering
	// --------------------------------------------------
	always_comb begin
		if (fetch_wins) begin
			proc2mem_command_o = fetch.cmd;
			proc2mem_addr_o    = fetch.addr;
			proc2mem_data_o    = fetch.wdata;
			fetch.response     = mem2proc_response_i;
			dmem.response      = '0;
		end else begin
			proc2mem_command_o = dmem.cmd;
			proc2mem_addr_o    = dmem.addr;
			proc2mem_data_o    = dmem.wdata;
			fetch.response     = '0;
			dmem.response      = mem2proc_response_i;
		end
	end

	// only one port may be told it was accepted
	a_one_response: assert property (@(posedge clk) disable iff (rst)
		!((fetch.response != '0) && (dmem.response != '0)));

endmodule : mem_port_arbiter

//--- hw/dmem_port.sv
`timescale 1ns/1ps

module dmem_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dmem_req_i,
	input  logic                   dmem_we_i,
	input  mem_bus_pkg::mem_addr_t dmem_addr_i,
	input  mem_bus_pkg::mem_data_t dmem_wdata_i,
	input  mem_bus_pkg::mem_tag_t  mem2proc_tag_i,
	input  mem_bus_pkg::mem_data_t mem2proc_data_i,
	output logic                   dmem_busy_o,
	output logic                   dmem_ld_valid_o,
	output mem_bus_pkg::mem_data_t dmem_ld_data_o,
	output logic                   dmem_st_done_o,
	mem_req_if.requester           bus
);

	mem_port_cfg_pkg::port_state_e state_r;
	logic                          we_r;
	mem_bus_pkg::mem_addr_t        addr_r;
	mem_bus_pkg::mem_data_t        wdata_r;
	mem_bus_pkg::mem_tag_t         tag_r;
	mem_bus_pkg::mem_data_t        ld_data_r;
	logic                          ld_valid_r;
	logic                          st_done_r;
	logic                          accepted;
	logic                          tag_hit;

	assign accepted = (state_r == mem_port_cfg_pkg::ISSUE) && (bus.response != '0);
	assign tag_hit  = (state_r == mem_port_cfg_pkg::WAIT_TAG) && (mem2proc_tag_i == tag_r);

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state_r    <= mem_port_cfg_pkg::IDLE;
			ld_valid_r <= 1'b0;
			st_done_r  <= 1'b0;
		end else begin
			ld_valid_r <= tag_hit;
			// a store is finished once memory takes it
			st_done_r  <= accepted && we_r;
			case (state_r)
				mem_port_cfg_pkg::IDLE: begin
					if (dmem_req_i)
						state_r <= mem_port_cfg_pkg::ISSUE;
				end
				mem_port_cfg_pkg::ISSUE: begin
					if (accepted)
						state_r <= we_r ? mem_port_cfg_pkg::IDLE : mem_port_cfg_pkg::WAIT_TAG;
				end
				mem_port_cfg_pkg::WAIT_TAG: begin
					if (tag_hit)
						state_r <= mem_port_cfg_pkg::IDLE;
				end
				default: state_r <= mem_port_cfg_pkg::IDLE;
			endcase
		end
	end

	// request latch, tag and load word
	always_ff @(posedge clk) begin
		if ((state_r == mem_port_cfg_pkg::IDLE) && dmem_req_i) begin
			we_r    <= dmem_we_i;
			addr_r  <= dmem_addr_i;
			wdata_r <= dmem_wdata_i;
		end
		if (accepted)
			tag_r <= bus.response;
		if (tag_hit)
			ld_data_r <= mem2proc_data_i;
	end

	always_comb begin
		bus.cmd = mem_bus_pkg::BUS_NONE;
		if (state_r == mem_port_cfg_pkg::ISSUE)
			bus.cmd = we_r ? mem_bus_pkg::BUS_STORE : mem_bus_pkg::BUS_LOAD;
	end

	assign bus.addr  = addr_r;
	assign bus.wdata = wdata_r;

	assign dmem_busy_o     = (state_r != mem_port_cfg_pkg::IDLE);
	assign dmem_ld_valid_o = ld_valid_r;
	assign dmem_ld_data_o  = ld_data_r;
	assign dmem_st_done_o  = st_done_r;

	a_dmem_stall_hold: assert property (@(posedge clk) disable iff (rst)
		(bus.cmd != mem_bus_pkg::BUS_NONE && bus.response == '0)
		|=> ($stable(bus.cmd) && $stable(bus.addr) && $stable(bus.wdata)));

	// accepted tag is always a real one
	a_dmem_tag_nonzero: assert property (@(posedge clk) disable iff (rst)
		(state_r == mem_port_cfg_pkg::WAIT_TAG) |-> (tag_r != '0));

	a_dmem_req_idle: assert property (@(posedge clk) disable iff (rst)
		dmem_req_i |-> !dmem_busy_o);

endmodule : dmem_port

//--- hw/fetch_port.sv
`timescale 1ns/1ps

module fetch_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   fetch_req_i,
	input  mem_bus_pkg::mem_addr_t fetch_addr_i,
	input  mem_bus_pkg::mem_tag_t  mem2proc_tag_i,
	input  mem_bus_pkg::mem_data_t mem2proc_data_i,
	output logic                   fetch_busy_o,
	output logic                   fetch_valid_o,
	output mem_bus_pkg::mem_data_t fetch_data_o,
	mem_req_if.requester           bus
);

	mem_port_cfg_pkg::port_state_e state_r;
	mem_bus_pkg::mem_addr_t        addr_r;
	mem_bus_pkg::mem_tag_t         tag_r;
	mem_bus_pkg::mem_data_t        data_r;
	logic                          valid_r;
	logic                          accepted;
	logic                          tag_hit;

	assign accepted = (state_r == mem_port_cfg_pkg::ISSUE) && (bus.response != '0);
	assign tag_hit  = (state_r == mem_port_cfg_pkg::WAIT_TAG) && (mem2proc_tag_i == tag_r);

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= mem_port_cfg_pkg::IDLE;
			valid_r <= 1'b0;
		end else begin
			valid_r <= tag_hit;
			case (state_r)
				mem_port_cfg_pkg::IDLE:     if (fetch_req_i) state_r <= mem_port_cfg_pkg::ISSUE;
				mem_port_cfg_pkg::ISSUE:    if (accepted) state_r <= mem_port_cfg_pkg::WAIT_TAG;
				mem_port_cfg_pkg::WAIT_TAG: if (tag_hit) state_r <= mem_port_cfg_pkg::IDLE;
				default:                    state_r <= mem_port_cfg_pkg::IDLE;
			endcase
		end
	end

	// address, tag and returned word
	always_ff @(posedge clk) begin
		if ((state_r == mem_port_cfg_pkg::IDLE) && fetch_req_i)
			addr_r <= fetch_addr_i;
		if (accepted)
			tag_r <= bus.response;
		if (tag_hit)
			data_r <= mem2proc_data_i;
	end

	// fetch only reads, so write data stays zero
	assign bus.cmd   = (state_r == mem_port_cfg_pkg::ISSUE) ? mem_bus_pkg::BUS_LOAD
	                                                        : mem_bus_pkg::BUS_NONE;
	assign bus.addr  = addr_r;
	assign bus.wdata = '0;

	assign fetch_busy_o  = (state_r != mem_port_cfg_pkg::IDLE);
	assign fetch_valid_o = valid_r;
	assign fetch_data_o  = data_r;

	// held command must not move while memory stalls it
	a_fetch_stall_hold: assert property (@(posedge clk) disable iff (rst)
		(bus.cmd != mem_bus_pkg::BUS_NONE && bus.response == '0)
		|=> ($stable(bus.cmd) && $stable(bus.addr) && $stable(bus.wdata)));

	// stimulus error, request while a fetch is in flight
	a_fetch_req_idle: assert property (@(posedge clk) disable iff (rst)
		fetch_req_i |-> !fetch_busy_o);

endmodule : fetch_port

//--- hw/mem_req_if.sv
`timescale 1ns/1ps

// one requester's command path into the arbiter
interface mem_req_if;

	mem_bus_pkg::mem_cmd_e  cmd;
	mem_bus_pkg::mem_addr_t addr;
	mem_bus_pkg::mem_data_t wdata;

	// acceptance tag, zero unless this side won and memory took it
	mem_bus_pkg::mem_tag_t  response;

	modport requester (
		output cmd,
		output addr,
		output wdata,
		input  response
	);

	modport arbiter (
		input  cmd,
		input  addr,
		input  wdata,
		output response
	);

endinterface : mem_req_if

//--- hw/mem_port_cfg_pkg.sv
package mem_port_cfg_pkg;

	// --------------------------------------------------
	// arbitration
	// --------------------------------------------------
	// fetch favored one cycle out of every ARB_VEC_W
	localparam int ARB_VEC_W = 4;

	// --------------------------------------------------
	// requester state machine
	// --------------------------------------------------
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_TAG
	} port_state_e;

endpackage : mem_port_cfg_pkg

//--- hw/mem_bus_pkg.sv
package mem_bus_pkg;

	// --------------------------------------------------
	// bus field widths
	// --------------------------------------------------
	localparam int ADDR_W = 64;
	localparam int DATA_W = 64;
	localparam int TAG_W  = 4;

	// command driven toward memory
	typedef enum logic [1:0] {
		BUS_NONE  = 2'b00,
		BUS_LOAD  = 2'b01,
		BUS_STORE = 2'b10
	} mem_cmd_e;

	// byte address, word aligned in practice
	typedef logic [ADDR_W-1:0] mem_addr_t;

	// one memory word
	typedef logic [DATA_W-1:0] mem_data_t;

	// transaction tag, zero means no response / no tag
	typedef logic [TAG_W-1:0] mem_tag_t;

endpackage : mem_bus_pkg
